/* tb.f */
+incdir+rtl
+incdir+bench
rtl/tcm_enc_pkg.sv
rtl/tcm_enc_dfc.sv
rtl/tcm_enc_conv.sv
rtl/tcm_enc_mapper.sv
rtl/tcm_enc_ctrl.sv
rtl/tcm_enc.sv
bench/tb_tcm_enc.sv

/* bench/tb_tcm_enc_model.svh */
/*
  reference model of the TCM coding chain and the typed compare tasks
*/
`ifndef TB_TCM_ENC_MODEL_SVH
`define TB_TCM_ENC_MODEL_SVH

  //------------------------------------------------------------------
  // compare tasks
  //------------------------------------------------------------------

  task automatic check_label(input string name, input tcm_enc_pkg::label_t got,
                             input tcm_enc_pkg::label_t exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input tcm_enc_pkg::coded_t got,
                            input tcm_enc_pkg::coded_t exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  //------------------------------------------------------------------
  // coding chain, one 4D word
  //------------------------------------------------------------------

  // differential accumulator and conv state
  logic [1:0]               m_acc;
  logic [`TCM_STATE_W-1:0]  m_state;

  task automatic encode_word(input logic s, input logic e, input tcm_enc_pkg::info_t dat);
    tcm_enc_pkg::info_t       m;
    tcm_enc_pkg::coded_t      c;
    tcm_enc_pkg::label_t      b;
    logic [`TCM_STATE_W-1:0]  st;
    logic                     p;
    m = dat;
    // bits above 10-code carry nothing
    for (int i = 0; i < `TCM_DAT_W; i++) begin
      if (i > `TCM_DAT_W - 1 - int'(code)) begin
        m[i] = 1'b0;
      end
    end
    // bits 3:2 become a running sum mod 4, restarted by sop
    m_acc  = (s ? 2'd0 : m_acc) + m[3:2];
    m[3:2] = m_acc;
    // parity is state bit 0 of the frame's state
    st = s ? {`TCM_STATE_W{1'b0}} : m_state;
    p  = st[0];
    c  = {m, p};
    m_state = (st >> 1) ^ (p ? `TCM_H0 : {`TCM_STATE_W{1'b0}})
            ^ (m[0] ? `TCM_H1 : {`TCM_STATE_W{1'b0}})
            ^ (m[1] ? `TCM_H2 : {`TCM_STATE_W{1'b0}});
    coded_q.push_back(c);
    // four labels, lowest bits first, each Gray coded
    for (int k = 0; k < `TCM_SYM_PER_4D; k++) begin
      b = c[3*k +: 3];
      lab_q.push_back({b[2], b[2] ^ b[1], b[1] ^ b[0]});
      sop_q.push_back(s && (k == 0));
      eop_q.push_back(e && (k == `TCM_SYM_PER_4D - 1));
    end
  endtask

`endif

/* bench/tb_tcm_enc.sv */
/*
  testbench for the 4D-8PSK TCM encoder
  random frames, rate codes, ticks and enable stalls against a model
*/
`timescale 1ns/1ps
`default_nettype none

`include "tcm_enc_consts.svh"

module tb_tcm_enc;

  logic                 iclk;
  logic                 rst_n;
  logic                 clkena;
  tcm_enc_pkg::code_t   code;
  logic                 tick;
  logic                 word_val;
  logic                 word_sop;
  logic                 word_eop;
  tcm_enc_pkg::info_t   word_dat;
  logic                 sym_tick;
  logic                 sym_val;
  logic                 sym_sop;
  logic                 sym_eop;
  tcm_enc_pkg::label_t  sym_dat;

  // expected symbols and coded words, in output order
  tcm_enc_pkg::label_t  lab_q[$];
  logic                 sop_q[$];
  logic                 eop_q[$];
  tcm_enc_pkg::coded_t  coded_q[$];

  // dfc and conv valid stages, symbols left of the loaded word
  logic [1:0]           pipe;
  int                   emit_left;
  logic                 exp_fresh;
  logic                 val_hold;
  int                   tick_wait;
  int                   stall;
  int                   words_sent;
  int                   syms_seen;
  int                   nw;
  tcm_enc_pkg::info_t   frame_dat[6];

  tcm_enc i_dut (
    .iclk     ( iclk     ) , .rst_n    ( rst_n    ) , .clkena   ( clkena   ) ,
    .code     ( code     ) , .tick     ( tick     ) ,
    .word_val ( word_val ) , .word_sop ( word_sop ) , .word_eop ( word_eop ) ,
    .word_dat ( word_dat ) , .sym_tick ( sym_tick ) ,
    .sym_val  ( sym_val  ) , .sym_sop  ( sym_sop  ) , .sym_eop  ( sym_eop  ) ,
    .sym_dat  ( sym_dat  )
  );

  initial begin
    iclk = 1'b0;
    forever #4 iclk = ~iclk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  `include "tb_tcm_enc_model.svh"

  //------------------------------------------------------------------
  // per-cycle monitor and edge prediction
  //------------------------------------------------------------------

  // at the falling edge, clkena and tick still hold the last edge's values
  task automatic observe_outputs();
    if (clkena) begin
      check_flag("sym_tick", sym_tick, tick);
      check_flag("sym_val", sym_val, exp_fresh);
    end else begin
      // frozen edge, output holds
      check_flag("sym_val", sym_val, val_hold);
    end
    val_hold = sym_val;
    if (clkena && sym_val) begin
      if (lab_q.size() == 0) begin
        abort_run("a symbol came out while no word was pending");
      end
      check_label("sym_dat", sym_dat, lab_q.pop_front());
      check_flag("sym_sop", sym_sop, sop_q.pop_front());
      check_flag("sym_eop", sym_eop, eop_q.pop_front());
      syms_seen++;
    end else if (clkena) begin
      check_flag("sym_sop", sym_sop, 1'b0);
      check_flag("sym_eop", sym_eop, 1'b0);
    end
  endtask

  // what the coming rising edge does
  task automatic predict_edge();
    exp_fresh = clkena & tick & (emit_left > 0);
    if (exp_fresh) begin
      emit_left--;
    end
    if (clkena && pipe[1]) begin
      // mapper loads this coded word now
      check_word("conv_dat", i_dut.conv_dat, coded_q.pop_front());
      emit_left = `TCM_SYM_PER_4D;
    end
    if (clkena) begin
      pipe = {pipe[0], word_val};
    end
  endtask

  //------------------------------------------------------------------
  // stimulus
  //------------------------------------------------------------------

  task automatic drive_cycle(input logic send, input logic s, input logic e,
                             input tcm_enc_pkg::info_t dat);
    @(negedge iclk);
    observe_outputs();
    // tick 2 to 5 cycles apart
    if (tick_wait == 0) begin
      tick      = 1'b1;
      tick_wait = $urandom_range(4, 1);
    end else begin
      tick = 1'b0;
      tick_wait--;
    end
    // word cycles always enabled, otherwise short dips and longer stalls
    if (send) begin
      clkena = 1'b1;
    end else if (stall > 0) begin
      clkena = 1'b0;
      stall--;
    end else if ($urandom_range(19, 0) == 0) begin
      clkena = 1'b0;
      stall  = $urandom_range(6, 2);
    end else begin
      clkena = ($urandom_range(9, 0) != 0);
    end
    word_val = send;
    word_sop = send & s;
    word_eop = send & e;
    word_dat = send ? dat : tcm_enc_pkg::info_t'($urandom);
    predict_edge();
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, 1'b0, 1'b0, '0);
  endtask

  task automatic send_word(input logic s, input logic e, input tcm_enc_pkg::info_t dat);
    int n;
    encode_word(s, e, dat);
    drive_cycle(1'b1, s, e, dat);
    words_sent++;
    n = 0;
    // all four symbols out before the next word
    while (syms_seen < `TCM_SYM_PER_4D * words_sent) begin
      idle_cycle();
      n++;
      if (n > 600) begin
        abort_run("timeout while waiting for the symbols of a word");
      end
    end
  endtask

  initial begin
    void'($urandom(69));
    rst_n      = 1'b0;
    clkena     = 1'b1;
    code       = '0;
    tick       = 1'b0;
    word_val   = 1'b0;
    word_sop   = 1'b0;
    word_eop   = 1'b0;
    word_dat   = '0;
    pipe       = '0;
    emit_left  = 0;
    exp_fresh  = 1'b0;
    val_hold   = 1'b0;
    tick_wait  = 2;
    stall      = 0;
    words_sent = 0;
    syms_seen  = 0;
    nw         = 0;
    m_acc      = '0;
    m_state    = '0;
    repeat (3) @(posedge iclk);
    @(negedge iclk);
    rst_n = 1'b1;
    // quiet after reset
    repeat (12) idle_cycle();
    for (int f = 0; f < 80; f++) begin
      // about one frame in five repeats the previous one
      if (f == 0 || $urandom_range(4, 0) != 0) begin
        code = tcm_enc_pkg::code_t'($urandom_range(3, 0));
        nw   = $urandom_range(6, 1);
        for (int j = 0; j < nw; j++) begin
          frame_dat[j] = tcm_enc_pkg::info_t'($urandom);
        end
      end
      for (int j = 0; j < nw; j++) begin
        send_word(j == 0, j == nw - 1, frame_dat[j]);
      end
      repeat ($urandom_range(3, 0)) idle_cycle();
    end
    repeat (30) idle_cycle();
    if (syms_seen == `TCM_SYM_PER_4D * words_sent && lab_q.size() == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      abort_run($sformatf("%0d symbols seen for %0d words sent", syms_seen, words_sent));
    end
  end

endmodule

`default_nettype wire

/* rtl/tcm_enc.sv */
/*
  4D-8PSK TCM encoder top
  diff coder, convolutional coder and mapper around the sequencer
*/
`timescale 1ns/1ps
`default_nettype none

module tcm_enc (
  input  logic                 iclk,
  input  logic                 rst_n,
  input  logic                 clkena,
  // rate code, a level
  input  tcm_enc_pkg::code_t   code,
  // symbol rate strobe
  input  logic                 tick,
  // one 4D word per strobe
  input  logic                 word_val,
  input  logic                 word_sop,
  input  logic                 word_eop,
  input  tcm_enc_pkg::info_t   word_dat,
  // 8PSK symbol side
  output logic                 sym_tick,
  output logic                 sym_val,
  output logic                 sym_sop,
  output logic                 sym_eop,
  output tcm_enc_pkg::label_t  sym_dat
);

  //------------------------------------------------------------------
  // internal nets
  //------------------------------------------------------------------

  logic                   dfc_val;
  logic                   dfc_sop;
  logic                   dfc_eop;
  tcm_enc_pkg::info_t     dfc_dat;

  logic                   conv_val;
  logic                   conv_sop;
  logic                   conv_eop;
  tcm_enc_pkg::coded_t    conv_dat;

  // sequencer to mapper
  logic                   load;
  logic                   emit;
  tcm_enc_pkg::sym_idx_t  sel;

  //------------------------------------------------------------------
  // datapath
  //------------------------------------------------------------------

  tcm_enc_dfc dfc (
    .iclk     ( iclk     ) , .rst_n    ( rst_n    ) , .clkena   ( clkena   ) ,
    .code     ( code     ) ,
    .val      ( word_val ) , .sop      ( word_sop ) , .eop      ( word_eop ) ,
    .dat      ( word_dat ) ,
    .dfc_val  ( dfc_val  ) , .dfc_sop  ( dfc_sop  ) , .dfc_eop  ( dfc_eop  ) ,
    .dfc_dat  ( dfc_dat  )
  );

  tcm_enc_conv conv (
    .iclk     ( iclk     ) , .rst_n    ( rst_n    ) , .clkena   ( clkena   ) ,
    .val      ( dfc_val  ) , .sop      ( dfc_sop  ) , .eop      ( dfc_eop  ) ,
    .dat      ( dfc_dat  ) ,
    .conv_val ( conv_val ) , .conv_sop ( conv_sop ) , .conv_eop ( conv_eop ) ,
    .conv_dat ( conv_dat )
  );

  tcm_enc_mapper mapper (
    .iclk     ( iclk     ) , .rst_n    ( rst_n    ) , .clkena   ( clkena   ) ,
    .load     ( load     ) , .word     ( conv_dat ) ,
    .emit     ( emit     ) , .sel      ( sel      ) ,
    .sym_val  ( sym_val  ) , .sym_dat  ( sym_dat  )
  );

  //------------------------------------------------------------------
  // control
  //------------------------------------------------------------------

  tcm_enc_ctrl ctrl (
    .iclk     ( iclk     ) , .rst_n    ( rst_n    ) , .clkena   ( clkena   ) ,
    .tick     ( tick     ) ,
    .conv_val ( conv_val ) , .conv_sop ( conv_sop ) , .conv_eop ( conv_eop ) ,
    .load     ( load     ) , .emit     ( emit     ) , .sel      ( sel      ) ,
    .sym_sop  ( sym_sop  ) , .sym_eop  ( sym_eop  ) , .sym_tick ( sym_tick )
  );

endmodule

`default_nettype wire

/* rtl/tcm_enc_ctrl.sv */
/*
  symbol sequencer
  loads the mapper, emits four symbols on ticks, frame markers
*/
`timescale 1ns/1ps
`default_nettype none

`include "tcm_enc_consts.svh"

module tcm_enc_ctrl (
  input  logic                   iclk,
  input  logic                   rst_n,
  input  logic                   clkena,
  input  logic                   tick,
  input  logic                   conv_val,
  input  logic                   conv_sop,
  input  logic                   conv_eop,
  output logic                   load,
  output logic                   emit,
  output tcm_enc_pkg::sym_idx_t  sel,
  output logic                   sym_sop,
  output logic                   sym_eop,
  output logic                   sym_tick
);

  //------------------------------------------------------------------
  // sequencer state
  //------------------------------------------------------------------

  // symbols of the held word still pending
  logic                   busy;
  tcm_enc_pkg::sym_idx_t  cnt;
  // frame flags of the held word
  logic                   frm_sop;
  logic                   frm_eop;
  // final symbol of the word
  logic                   last;

  // every coded word goes straight into the mapper
  assign load = conv_val;

  // busy only rises after the load cycle
  assign emit = busy & tick;
  assign sel  = cnt;
  assign last = (cnt == tcm_enc_pkg::sym_idx_t'(`TCM_SYM_PER_4D - 1));

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      cnt      <= '0;
      frm_sop  <= 1'b0;
      frm_eop  <= 1'b0;
      sym_sop  <= 1'b0;
      sym_eop  <= 1'b0;
      sym_tick <= 1'b0;
    end else if (clkena) begin
      sym_tick <= tick;
      // markers line up with the mapper output register
      sym_sop  <= emit & frm_sop & (cnt == '0);
      sym_eop  <= emit & frm_eop & last;
      if (load) begin
        // new word restarts the count
        busy    <= 1'b1;
        cnt     <= '0;
        frm_sop <= conv_sop;
        frm_eop <= conv_eop;
      end else if (emit) begin
        cnt <= cnt + 1'b1;
        if (last) begin
          busy <= 1'b0;
        end
      end
    end
  end

  //------------------------------------------------------------------
  // checks
  //------------------------------------------------------------------

  // source must leave room for all four symbols of a word
  a_no_overrun : assert property (
    @(posedge iclk) disable iff (!rst_n)
    conv_val |-> !busy
  ) else $error("tcm_enc_ctrl: word arrived with symbols still pending");

endmodule

`default_nettype wire

/* rtl/tcm_enc_mapper.sv */
/*
  8PSK mapper
  holds the coded word, picks one label per emit, Gray codes it
*/
`timescale 1ns/1ps
`default_nettype none

module tcm_enc_mapper (
  input  logic                   iclk,
  input  logic                   rst_n,
  input  logic                   clkena,
  input  logic                   load,
  input  tcm_enc_pkg::coded_t    word,
  input  logic                   emit,
  input  tcm_enc_pkg::sym_idx_t  sel,
  output logic                   sym_val,
  output tcm_enc_pkg::label_t    sym_dat
);

  //------------------------------------------------------------------
  // word holding register
  //------------------------------------------------------------------

  tcm_enc_pkg::coded_t  word_r;
  // natural label and its Gray code
  tcm_enc_pkg::label_t  b;
  tcm_enc_pkg::label_t  gray;

  // loaded once per 4D word
  always_ff @(posedge iclk) begin
    if (clkena && load) begin
      word_r <= word;
    end
  end

  //------------------------------------------------------------------
  // label select and Gray mapping
  //------------------------------------------------------------------

  // label sel sits at bits 3*sel+2 .. 3*sel
  assign b    = word_r[int'(sel) * 3 +: 3];
  // adjacent phases differ by one bit
  assign gray = b ^ (b >> 1);

  // one symbol per emit
  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      sym_val <= 1'b0;
    end else if (clkena) begin
      sym_val <= emit;
    end
  end

  always_ff @(posedge iclk) begin
    if (clkena && emit) begin
      sym_dat <= gray;
    end
  end

endmodule

`default_nettype wire

/* rtl/tcm_enc_conv.sv */
/*
  systematic feedback convolutional coder
  appends one parity bit to the information word
*/
`timescale 1ns/1ps
`default_nettype none

`include "tcm_enc_consts.svh"

module tcm_enc_conv (
  input  logic                 iclk,
  input  logic                 rst_n,
  input  logic                 clkena,
  input  logic                 val,
  input  logic                 sop,
  input  logic                 eop,
  input  tcm_enc_pkg::info_t   dat,
  output logic                 conv_val,
  output logic                 conv_sop,
  output logic                 conv_eop,
  output tcm_enc_pkg::coded_t  conv_dat
);

  //------------------------------------------------------------------
  // encoder state
  //------------------------------------------------------------------

  logic [`TCM_STATE_W-1:0]  state;
  logic [`TCM_STATE_W-1:0]  st_cur;
  logic [`TCM_STATE_W-1:0]  st_nxt;
  // parity bit of the current word
  logic                     p;

  // a frame always starts from the zero state
  assign st_cur = sop ? '0 : state;

  // systematic code, parity comes straight from the state
  assign p = st_cur[0];

  // shift right, then fold in the feedback taps
  assign st_nxt = (st_cur >> 1)
                ^ (p      ? `TCM_H0 : '0)
                ^ (dat[0] ? `TCM_H1 : '0)
                ^ (dat[1] ? `TCM_H2 : '0);

  //------------------------------------------------------------------
  // registers
  //------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      conv_val <= 1'b0;
      conv_sop <= 1'b0;
      conv_eop <= 1'b0;
      state    <= '0;
    end else if (clkena) begin
      conv_val <= val;
      conv_sop <= sop;
      conv_eop <= eop;
      if (val) begin
        state <= st_nxt;
      end
    end
  end

  // coded word, parity goes to bit 0
  always_ff @(posedge iclk) begin
    if (clkena && val) begin
      conv_dat <= {dat, p};
    end
  end

  // frame markers from the diff coder must ride on a word
  a_flag_with_val : assert property (
    @(posedge iclk) disable iff (!rst_n)
    (sop || eop) |-> val
  ) else $error("tcm_enc_conv: sop/eop seen without val");

endmodule

`default_nettype wire

/* rtl/tcm_enc_dfc.sv */
/*
  differential coder
  masks unused bits per rate code, diff codes bits 3:2
*/
`timescale 1ns/1ps
`default_nettype none

`include "tcm_enc_consts.svh"

module tcm_enc_dfc (
  input  logic                iclk,
  input  logic                rst_n,
  input  logic                clkena,
  input  tcm_enc_pkg::code_t  code,
  input  logic                val,
  input  logic                sop,
  input  logic                eop,
  input  tcm_enc_pkg::info_t  dat,
  output logic                dfc_val,
  output logic                dfc_sop,
  output logic                dfc_eop,
  output tcm_enc_pkg::info_t  dfc_dat
);

  //------------------------------------------------------------------
  // rate masking
  //------------------------------------------------------------------

  tcm_enc_pkg::info_t  mask;
  tcm_enc_pkg::info_t  dat_m;
  // differential accumulator and its next value
  logic [1:0]          acc;
  logic [1:0]          d;

  // keep bits 10-code down to 0
  assign mask  = {`TCM_DAT_W{1'b1}} >> code;
  assign dat_m = dat & mask;

  //------------------------------------------------------------------
  // differential coding of bits 3:2
  //------------------------------------------------------------------

  // modulo 4 sum, restarts from zero on a sop word
  assign d = (sop ? 2'd0 : acc) + dat_m[3:2];

  // control and accumulator
  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      dfc_val <= 1'b0;
      dfc_sop <= 1'b0;
      dfc_eop <= 1'b0;
      acc     <= 2'd0;
    end else if (clkena) begin
      dfc_val <= val;
      // markers only count with a word
      dfc_sop <= val & sop;
      dfc_eop <= val & eop;
      if (val) begin
        acc <= d;
      end
    end
  end

  // payload, coded pair replaces bits 3:2
  always_ff @(posedge iclk) begin
    if (clkena && val) begin
      dfc_dat <= {dat_m[`TCM_DAT_W-1:4], d, dat_m[1:0]};
    end
  end

endmodule

`default_nettype wire

/* rtl/tcm_enc_pkg.sv */
/*
  4D-8PSK TCM encoder shared types
*/
`default_nettype none

`include "tcm_enc_consts.svh"

package tcm_enc_pkg;

  //------------------------------------------------------------------
  // input side
  //------------------------------------------------------------------

  // rate code, 0/1/2/3 carry 11/10/9/8 information bits
  typedef logic [1:0] code_t;

  // 4D information word, unused high bits masked by the rate code
  typedef logic [`TCM_DAT_W-1:0] info_t;

  //------------------------------------------------------------------
  // coded side
  //------------------------------------------------------------------

  // information word with parity as bit 0
  typedef logic [`TCM_CODED_W-1:0] coded_t;

  // one 8PSK label
  typedef logic [2:0] label_t;

  // position of a symbol inside its 4D word
  typedef logic [$clog2(`TCM_SYM_PER_4D)-1:0] sym_idx_t;

endpackage

`default_nettype wire

/* rtl/tcm_enc_consts.svh */
/*
  4D-8PSK TCM encoder constants
  word widths, symbols per 4D word and parity feedback masks
*/
`ifndef TCM_ENC_CONSTS_SVH
`define TCM_ENC_CONSTS_SVH

//--------------------------------------------------------------------
// word widths
//--------------------------------------------------------------------

// information bits, rate code 0 uses all of them
`define TCM_DAT_W       11

// information bits plus one parity bit
`define TCM_CODED_W     12

// 8PSK symbols that make up one 4D word
`define TCM_SYM_PER_4D  4

//--------------------------------------------------------------------
// convolutional coder
//--------------------------------------------------------------------

// state register width
`define TCM_STATE_W     6

// feedback masks, parity bit then information bits 0 and 1
`define TCM_H0          6'h23
`define TCM_H1          6'h0a
`define TCM_H2          6'h14

`endif
